// ==== source/adc_retime_defs.svh ====
`ifndef ADC_RETIME_DEFS_SVH
`define ADC_RETIME_DEFS_SVH

// one lane sample as delivered by the adc
`define ADC_SAMPLE_W 24

// lanes packed into each capture word
`define ADC_LANES 4

// full capture word, lane 0 in the low bits
`define ADC_FRAME_W (`ADC_SAMPLE_W * `ADC_LANES)

// fifo address bits, 16 entries
`define ADC_FIFO_AW 4

`endif

// ==== source/adc_retime_pkg.sv ====
`default_nettype none

`include "adc_retime_defs.svh"

package adc_retime_pkg;

  // one capture word, seen either flat or per lane
  // lanes[0] sits in the least significant bits
  typedef union packed {
    logic [`ADC_FRAME_W-1:0]                    raw;
    logic [`ADC_LANES-1:0][`ADC_SAMPLE_W-1:0]   lanes;
  } adc_frame_u;

  // fifo payload, sync marks lane 0 of a frame
  typedef struct packed {
    logic                     sync;
    logic [`ADC_SAMPLE_W-1:0] sample;
  } sample_word_t;

  // read-domain status
  // underflow is a pulse, overflow is sticky
  typedef struct packed {
    logic empty;
    logic underflow;
    logic overflow;
  } fifo_status_t;

endpackage

`default_nettype wire

// ==== source/adc_stream_mux.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "adc_retime_defs.svh"

module adc_stream_mux import adc_retime_pkg::*; (
  input  wire          wr_clk,
  input  wire          reset,
  input  wire          dvld,
  input  wire          adc_frame_u din,
  output sample_word_t mux_word,
  output logic         mux_vld
);

  localparam int LANE_W = $clog2(`ADC_LANES);
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`ADC_LANES - 1);

  // held copy of the frame being emitted
  adc_frame_u        frame_q;
  // lane to emit on the next edge
  logic [LANE_W-1:0] lane_cnt;
  // frame in progress, lanes 1..3 still pending
  logic              busy;
  logic              accept;

  // new frame only taken once lane 3 is out
  assign accept = dvld & ~busy;

  // control path
  always_ff @(posedge wr_clk) begin
    if (reset) begin
      busy     <= 1'b0;
      lane_cnt <= '0;
      mux_vld  <= 1'b0;
    end else begin
      // lane 0 goes out on the accept edge, then three more
      mux_vld <= accept | busy;
      if (accept) begin
        busy     <= 1'b1;
        lane_cnt <= LANE_W'(1);
      end else if (busy) begin
        lane_cnt <= lane_cnt + 1'b1;
        // last lane leaves on this edge
        if (lane_cnt == LAST_LANE) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // data path
  always_ff @(posedge wr_clk) begin
    if (accept) begin
      frame_q.raw     <= din.raw;
      // lane 0 straight from the port, saves a cycle
      mux_word.sync   <= 1'b1;
      mux_word.sample <= din.lanes[0];
    end else begin
      mux_word.sync   <= 1'b0;
      // don't care when idle, mux_vld qualifies it
      mux_word.sample <= frame_q.lanes[lane_cnt];
    end
  end

endmodule

`default_nettype wire

// ==== source/gray_sync.sv ====
`default_nettype none
`timescale 1ns/1ps

module gray_sync #(
  parameter int WIDTH = 5
) (
  input  wire              src_clk,
  input  wire              dst_clk,
  input  wire              reset,
  input  wire  [WIDTH-1:0] bin_in,
  output logic [WIDTH-1:0] gray_out
);

  // gray value launched from a flop, never from logic
  logic [WIDTH-1:0] gray_src;
  // first capture stage, may go metastable
  logic [WIDTH-1:0] gray_meta;

  // source side encode
  // for width 1 this is just a copy of the bit
  always_ff @(posedge src_clk) begin
    if (reset) begin
      gray_src <= '0;
    end else begin
      gray_src <= bin_in ^ (bin_in >> 1);
    end
  end

  // two-flop capture in the destination domain
  always_ff @(posedge dst_clk) begin
    if (reset) begin
      gray_meta <= '0;
      gray_out  <= '0;
    end else begin
      gray_meta <= gray_src;
      gray_out  <= gray_meta;
    end
  end

endmodule

`default_nettype wire

// ==== source/async_sample_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "adc_retime_defs.svh"

module async_sample_fifo import adc_retime_pkg::*; (
  input  wire          wr_clk,
  input  wire          rd_clk,
  input  wire          reset,
  input  wire          wr_en,
  input  wire          rd_en,
  input  wire          sample_word_t wr_word,
  output sample_word_t rd_word,
  output fifo_status_t status
);

  localparam int AW    = `ADC_FIFO_AW;
  localparam int DEPTH = 1 << AW;

  // storage, no reset on payload
  sample_word_t mem [DEPTH];

  // binary pointers, msb is the wrap bit
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  // read pointer as seen from wr_clk
  logic [AW:0] rd_ptr_gray_wr;
  logic [AW:0] rd_ptr_bin_wr;

  // write pointer as seen from rd_clk
  logic [AW:0] wr_ptr_gray_rd;
  logic [AW:0] wr_ptr_bin_rd;

  logic full;
  logic empty;
  // sticky overflow, write side and its rd_clk copy
  logic of_wr;
  logic of_rd;
  // one-cycle underflow pulse
  logic uf_q;

  // gray back to binary, msb first
  function automatic logic [AW:0] gray_to_bin(input logic [AW:0] gray);
    logic [AW:0] bin;
    bin[AW] = gray[AW];
    for (int i = AW - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  // pointer crossings
  gray_sync #(.WIDTH(AW + 1)) i_wr_ptr_sync (
    .src_clk  (wr_clk),
    .dst_clk  (rd_clk),
    .reset    (reset),
    .bin_in   (wr_ptr),
    .gray_out (wr_ptr_gray_rd)
  );

  gray_sync #(.WIDTH(AW + 1)) i_rd_ptr_sync (
    .src_clk  (rd_clk),
    .dst_clk  (wr_clk),
    .reset    (reset),
    .bin_in   (rd_ptr),
    .gray_out (rd_ptr_gray_wr)
  );

  // overflow flag crossing, single bit so gray is a no-op
  gray_sync #(.WIDTH(1)) i_of_sync (
    .src_clk  (wr_clk),
    .dst_clk  (rd_clk),
    .reset    (reset),
    .bin_in   (of_wr),
    .gray_out (of_rd)
  );

  assign rd_ptr_bin_wr = gray_to_bin(rd_ptr_gray_wr);
  assign wr_ptr_bin_rd = gray_to_bin(wr_ptr_gray_rd);

  // full when addresses match and wrap bits differ
  // pessimistic, the synced read pointer lags
  assign full = (wr_ptr[AW] != rd_ptr_bin_wr[AW]) &&
                (wr_ptr[AW-1:0] == rd_ptr_bin_wr[AW-1:0]);

  // empty on full pointer match, also lags the writer
  assign empty = (rd_ptr == wr_ptr_bin_rd);

  // write side control
  always_ff @(posedge wr_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      of_wr  <= 1'b0;
    end else if (wr_en) begin
      if (full) begin
        // write dropped, flag held until reset
        of_wr <= 1'b1;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // storage write
  always_ff @(posedge wr_clk) begin
    if (wr_en && !full) begin
      mem[wr_ptr[AW-1:0]] <= wr_word;
    end
  end

  // read side control
  always_ff @(posedge rd_clk) begin
    if (reset) begin
      rd_ptr <= '0;
      uf_q   <= 1'b0;
    end else begin
      uf_q <= rd_en & empty;
      if (rd_en && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // head entry, show-ahead style
  assign rd_word = mem[rd_ptr[AW-1:0]];

  assign status = '{empty: empty, underflow: uf_q, overflow: of_rd};

endmodule

`default_nettype wire

// ==== source/adc_retime.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "adc_retime_defs.svh"

module adc_retime import adc_retime_pkg::*; (
  input  wire                      wr_clk,
  input  wire                      rd_clk,
  input  wire                      reset,
  input  wire                      dvld,
  input  wire                      rd_en,
  input  wire                      adc_frame_u din,
  output logic [`ADC_SAMPLE_W-1:0] dout,
  output logic                     dout_sync,
  output logic                     dout_vld,
  output logic                     fifo_empty,
  output logic                     fifo_uf,
  output logic                     fifo_of
);

  // multiplexer output
  sample_word_t mux_word;
  logic         mux_vld;

  // one stage between multiplexer and fifo
  sample_word_t pipe_word;
  logic         pipe_vld;

  // read side
  logic         rd_en_q;
  sample_word_t rd_word;
  fifo_status_t fifo_st;
  // an entry actually leaves the fifo this edge
  logic         pop;

  // frame to sample stream
  adc_stream_mux i_adc_stream_mux (
    .wr_clk   (wr_clk),
    .reset    (reset),
    .dvld     (dvld),
    .din      (din),
    .mux_word (mux_word),
    .mux_vld  (mux_vld)
  );

  // pipeline register, valid only is reset
  always_ff @(posedge wr_clk) begin
    if (reset) begin
      pipe_vld <= 1'b0;
    end else begin
      pipe_vld <= mux_vld;
    end
  end

  always_ff @(posedge wr_clk) begin
    pipe_word <= mux_word;
  end

  // clock crossing
  async_sample_fifo i_async_sample_fifo (
    .wr_clk  (wr_clk),
    .rd_clk  (rd_clk),
    .reset   (reset),
    .wr_en   (pipe_vld),
    .rd_en   (rd_en_q),
    .wr_word (pipe_word),
    .rd_word (rd_word),
    .status  (fifo_st)
  );

  // same condition the fifo uses to advance its read pointer
  assign pop = rd_en_q & ~fifo_st.empty;

  // read-side control registers
  // rd_en at edge n gives dout_vld at edge n+2
  always_ff @(posedge rd_clk) begin
    if (reset) begin
      rd_en_q    <= 1'b0;
      dout_vld   <= 1'b0;
      fifo_empty <= 1'b1;
    end else begin
      rd_en_q    <= rd_en;
      dout_vld   <= pop;
      fifo_empty <= fifo_st.empty;
    end
  end

  // output data, held between pops
  always_ff @(posedge rd_clk) begin
    if (pop) begin
      dout      <= rd_word.sample;
      dout_sync <= rd_word.sync;
    end
  end

  // status flags already registered inside the fifo
  assign fifo_uf = fifo_st.underflow;
  assign fifo_of = fifo_st.overflow;

endmodule

`default_nettype wire

// ==== testbench/adc_retime_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "adc_retime_defs.svh"

module adc_retime_tb import adc_retime_pkg::*; ();

  localparam int SW           = `ADC_SAMPLE_W;
  localparam int FIFO_DEPTH   = 1 << `ADC_FIFO_AW;
  localparam int RESET_CYCLES = 8;
  localparam int WAIT_LIMIT   = 2000;

  logic       wr_clk;
  logic       rd_clk;
  logic       reset;
  logic       dvld;
  logic       rd_en;
  adc_frame_u din;
  logic [SW-1:0] dout;
  logic       dout_sync;
  logic       dout_vld;
  logic       fifo_empty;
  logic       fifo_uf;
  logic       fifo_of;

  // expected sample stream, four words per accepted frame
  sample_word_t ref_q[$];
  // wr cycles until the frame model takes a new dvld
  int    frame_gap = 0;
  int    rx_count = 0;
  int    errors = 0;
  int    errors_at_start = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  string test_name = "none";
  // rd_en and fifo_empty as seen at past rd_clk edges, bit 0 newest
  logic [3:0] rd_hist;
  logic [3:0] emp_hist;
  logic       of_seen;

  adc_retime i_adc_retime (
    .wr_clk     (wr_clk),
    .rd_clk     (rd_clk),
    .reset      (reset),
    .dvld       (dvld),
    .rd_en      (rd_en),
    .din        (din),
    .dout       (dout),
    .dout_sync  (dout_sync),
    .dout_vld   (dout_vld),
    .fifo_empty (fifo_empty),
    .fifo_uf    (fifo_uf),
    .fifo_of    (fifo_of)
  );

  // 10 ns reader, 8 ns writer so the writer can outrun it
  always #5 rd_clk = ~rd_clk;
  always #4 wr_clk = ~wr_clk;

  // frame model, dvld inside a running frame is dropped
  always @(posedge wr_clk) begin : frame_model
    sample_word_t w;
    if (reset) begin
      frame_gap <= 0;
    end else if (dvld && frame_gap == 0) begin
      for (int i = 0; i < `ADC_LANES; i++) begin
        w.sync   = (i == 0);
        w.sample = din.lanes[i];
        ref_q.push_back(w);
      end
      frame_gap <= `ADC_LANES - 1;
    end else if (frame_gap != 0) begin
      frame_gap <= frame_gap - 1;
    end
  end

  // read-side checks on every rd_clk edge
  always @(posedge rd_clk) begin : read_check
    sample_word_t got;
    sample_word_t exp;
    if (reset) begin
      rd_hist  <= '0;
      emp_hist <= '1;
      of_seen  <= 1'b0;
    end else begin
      got.sync   = dout_sync;
      got.sample = dout;
      if (dout_vld) begin
        rx_count++;
        assert (ref_q.size() > 0) else begin
          errors++;
          $display("%s: dout_vld rose with no sample left to expect", test_name);
        end
        if (ref_q.size() > 0) begin
          exp = ref_q.pop_front();
          assert (got == exp) else begin
            errors++;
            $display("MISMATCH %s: expected sync=%0b sample=%06h, actual sync=%0b sample=%06h",
                     test_name, exp.sync, exp.sample, got.sync, got.sample);
          end
        end
      end
      // dout_vld only answers rd_en two edges back
      assert (!dout_vld || rd_hist[1]) else begin
        errors++;
        $display("%s: dout_vld high without rd_en two edges earlier", test_name);
      end
      // isolated read with data present always pops
      assert (!(rd_hist[1] && !emp_hist[1] && !rd_hist[2] && !rd_hist[3]) || dout_vld)
      else begin
        errors++;
        $display("MISMATCH %s dout_vld at read latency: expected 1, actual 0", test_name);
      end
      // underflow answers a read, never with data
      assert (!fifo_uf || (rd_hist[1] && !dout_vld)) else begin
        errors++;
        $display("%s: fifo_uf pulsed without an empty read two edges earlier", test_name);
      end
      // overflow sticky until reset
      assert (!of_seen || fifo_of) else begin
        errors++;
        $display("MISMATCH %s fifo_of sticky: expected 1, actual 0", test_name);
      end
      if (fifo_of) begin
        of_seen <= 1'b1;
      end
      rd_hist  <= {rd_hist[2:0], rd_en};
      emp_hist <= {emp_hist[2:0], fifo_empty};
    end
  end

  task automatic check_bit(input string what, input logic exp, input logic act);
    assert (act === exp) else begin
      errors++;
      $display("MISMATCH %s %s: expected %0b, actual %0b", test_name, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    assert (act == exp) else begin
      errors++;
      $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
    end
    $display("test %s finished, %0d error(s)", test_name, errors - errors_at_start);
  endtask

  function automatic adc_frame_u random_frame();
    adc_frame_u f;
    for (int i = 0; i < `ADC_LANES; i++) begin
      f.lanes[i] = SW'($urandom());
    end
    return f;
  endfunction

  // called 1 ns after a wr_clk edge, dvld high for one cycle
  task automatic pulse_frame(input adc_frame_u f);
    din  = f;
    dvld = 1'b1;
    @(posedge wr_clk);
    #1;
    dvld = 1'b0;
  endtask

  // frames four wr cycles apart
  task automatic send_frames(input int count);
    for (int n = 0; n < count; n++) begin
      @(posedge wr_clk);
      #1;
      pulse_frame(random_frame());
      repeat (2) @(posedge wr_clk);
    end
  endtask

  task automatic wait_empty();
    int waited;
    waited = 0;
    while (fifo_empty !== 1'b1 && waited < WAIT_LIMIT) begin
      @(posedge rd_clk);
      #1;
      waited++;
    end
    if (fifo_empty !== 1'b1) begin
      errors++;
      $display("%s: fifo_empty never rose after the reads", test_name);
    end
  endtask

  task automatic wait_overflow();
    int waited;
    waited = 0;
    while (fifo_of !== 1'b1 && waited < WAIT_LIMIT) begin
      @(posedge rd_clk);
      #1;
      waited++;
    end
    if (fifo_of !== 1'b1) begin
      errors++;
      $display("%s: fifo_of never rose with the fifo full", test_name);
    end
  endtask

  // rd_en held until every expected sample is out
  task automatic drain_all();
    int waited;
    waited = 0;
    @(posedge rd_clk);
    #1;
    rd_en = 1'b1;
    while (ref_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge rd_clk);
      #1;
      waited++;
    end
    if (ref_q.size() != 0) begin
      errors++;
      $display("%s: %0d samples never came out of the fifo", test_name, ref_q.size());
    end
    rd_en = 1'b0;
    wait_empty();
    // reads still in flight land here
    repeat (3) @(posedge rd_clk);
    #1;
  endtask

  task automatic check_reset_state();
    start_test("reset_state");
    @(posedge rd_clk);
    #1;
    check_bit("dout_vld", 1'b0, dout_vld);
    check_bit("fifo_uf", 1'b0, fifo_uf);
    check_bit("fifo_of", 1'b0, fifo_of);
    check_bit("fifo_empty", 1'b1, fifo_empty);
    finish_test();
  endtask

  // three frames stay below the fifo depth with no reads running
  task automatic verify_order();
    int rx0;
    start_test("order_content");
    rx0 = rx_count;
    send_frames(3);
    drain_all();
    check_count("samples read", 3 * `ADC_LANES, rx_count - rx0);
    finish_test();
  endtask

  // single reads spaced out so each one hits the latency check
  task automatic verify_read_latency();
    int waited;
    start_test("read_latency");
    waited = 0;
    send_frames(2);
    @(posedge rd_clk);
    #1;
    while (ref_q.size() != 0 && waited < WAIT_LIMIT) begin
      if (fifo_empty === 1'b0) begin
        rd_en = 1'b1;
        @(posedge rd_clk);
        #1;
        rd_en = 1'b0;
        repeat (3) @(posedge rd_clk);
        #1;
      end else begin
        @(posedge rd_clk);
        #1;
      end
      waited++;
    end
    if (ref_q.size() != 0) begin
      errors++;
      $display("%s: single reads did not empty the fifo in time", test_name);
    end
    wait_empty();
    finish_test();
  endtask

  // no overflow has happened yet, so fifo_of must stay low
  task automatic provoke_underflow();
    start_test("underflow");
    send_frames(1);
    drain_all();
    rd_en = 1'b1;
    @(posedge rd_clk);
    #1;
    rd_en = 1'b0;
    check_bit("fifo_uf one edge after read", 1'b0, fifo_uf);
    @(posedge rd_clk);
    #1;
    // pulse sampled at the second edge
    check_bit("fifo_uf", 1'b1, fifo_uf);
    check_bit("dout_vld", 1'b0, dout_vld);
    @(posedge rd_clk);
    #1;
    check_bit("fifo_uf after pulse", 1'b0, fifo_uf);
    check_bit("fifo_of", 1'b0, fifo_of);
    finish_test();
  endtask

  task automatic drop_early_frame();
    int rx0;
    start_test("early_frame");
    rx0 = rx_count;
    @(posedge wr_clk);
    #1;
    pulse_frame(random_frame());
    // second dvld one cycle after the accepted one
    pulse_frame(random_frame());
    repeat (4) @(posedge wr_clk);
    check_count("queued samples", `ADC_LANES, ref_q.size());
    drain_all();
    check_count("samples read", `ADC_LANES, rx_count - rx0);
    finish_test();
  endtask

  task automatic overflow_and_recover();
    int rx0;
    start_test("overflow");
    rx0 = rx_count;
    check_bit("fifo_of before", 1'b0, fifo_of);
    send_frames(6);
    repeat (8) @(posedge wr_clk);
    wait_overflow();
    check_count("queued samples", 6 * `ADC_LANES, ref_q.size());
    // only the first 16 fit, the rest were dropped
    while (ref_q.size() > FIFO_DEPTH) begin
      void'(ref_q.pop_back());
    end
    drain_all();
    check_count("samples read", FIFO_DEPTH, rx_count - rx0);
    check_bit("fifo_empty after reads", 1'b1, fifo_empty);
    check_bit("fifo_of held", 1'b1, fifo_of);
    finish_test();
  endtask

  initial begin : main
    void'($urandom(32'h0d0e_19fc));
    wr_clk = 1'b0;
    rd_clk = 1'b0;
    reset  = 1'b1;
    dvld   = 1'b0;
    rd_en  = 1'b0;
    din    = '0;
    repeat (RESET_CYCLES) @(posedge rd_clk);
    #1;
    reset = 1'b0;
    check_reset_state();
    verify_order();
    verify_read_latency();
    provoke_underflow();
    drop_early_frame();
    overflow_and_recover();
    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // hard stop if the test sequence itself stalls
  initial begin : watchdog
    #2000000;
    $display("simulation time limit reached before the tests completed");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== adc_retime.f ====
+incdir+source
source/adc_retime_pkg.sv
source/adc_stream_mux.sv
source/gray_sync.sv
source/async_sample_fifo.sv
source/adc_retime.sv
testbench/adc_retime_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# verilator build and run of adc_retime_tb
# nonzero exit when the log holds the fail message

cd "$(dirname "$0")" || exit 1

top=adc_retime_tb
build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$top" -f adc_retime.f -o "$top" > "$build_log" 2>&1 \
  && ./obj_dir/"$top" > "$sim_log" 2>&1 \
  || { cat "$build_log"; echo "build or simulation did not complete"; exit 1; }

cat "$sim_log"

# decision from the simulation log only
grep -q "ERRORS FOUND" "$sim_log" \
  && { echo "simulation failed"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
